// ==== common/cache_line_pkg.sv ====
// Cacheline geometry, address and half-line types shared by the edge read path stages
package cache_line_pkg;

	//////////////////////////////
	// Line geometry
	//////////////////////////////

	// Bytes per cacheline
	localparam int CACHELINE_BYTES = 128;
	localparam int CACHELINE_BITS  = CACHELINE_BYTES * 8;
	// Memory returns each line as two halves
	localparam int HALF_LINE_BITS  = CACHELINE_BITS / 2;

	// One edge data word
	localparam int WORD_BITS      = 32;
	localparam int WORDS_PER_LINE = CACHELINE_BITS / WORD_BITS;
	localparam int WORDS_PER_HALF = WORDS_PER_LINE / 2;

	// Word offset inside a line
	localparam int OFFSET_BITS = $clog2(WORDS_PER_LINE);

	// Byte address width on the command bus
	localparam int ADDRESS_BITS = 64;

	//////////////////////////////
	// Types
	//////////////////////////////

	// Word k sits at bits 32k up to 32k+31
	typedef logic [HALF_LINE_BITS-1:0] half_line_t;
	typedef logic [OFFSET_BITS-1:0]    word_offset_t;
	typedef logic [ADDRESS_BITS-1:0]   line_address_t;

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// Memory order is big endian, host order little endian
	function automatic logic [WORD_BITS-1:0] swap_word_bytes(
		input logic [WORD_BITS-1:0] word
	);
		return {word[7:0], word[15:8], word[23:16], word[31:24]};
	endfunction

endpackage

// ==== common/compute_unit_pkg.sv ====
// Compute unit side types for edge requests and edge results of the read path
package compute_unit_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////

	// Id of the requesting compute unit
	localparam int CU_ID_BITS = 8;

	// Edge index as issued by a compute unit
	localparam int EDGE_INDEX_BITS = 32;

	// Result word width
	localparam int EDGE_WORD_BITS = 32;

	//////////////////////////////
	// Types
	//////////////////////////////

	// Travels with a command as part of its tag
	typedef logic [CU_ID_BITS-1:0] cu_id_t;

	// Low bits pick the word, the rest the line
	typedef logic [EDGE_INDEX_BITS-1:0] edge_index_t;

	// Host order result word
	typedef logic [EDGE_WORD_BITS-1:0] edge_word_t;

endpackage

// ==== common/line_pair_if.sv ====
// Paired cacheline bus from the response pairing stage to the word extract stage
`timescale 1ns/100ps

interface line_pair_if;
	import cache_line_pkg::*;
	import compute_unit_pkg::*;

	// One strobe per paired line
	// No handshake and no back-pressure
	logic valid;

	// Tag of the line, taken from half 0
	cu_id_t       cu_id;
	word_offset_t offset;

	// Lower and upper halves of the line
	half_line_t half_0;
	half_line_t half_1;

	// Pairing stage drives the line
	modport execute (
		output valid,
		output cu_id,
		output offset,
		output half_0,
		output half_1
	);

	// Extract stage consumes it
	modport result (
		input valid,
		input cu_id,
		input offset,
		input half_0,
		input half_1
	);

endinterface

// ==== hdl/edge_read_request_decode.sv ====
// Request decode stage, turns an edge index into a tagged cacheline read command
`timescale 1ns/100ps

module edge_read_request_decode (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          enabled_in,
	input  logic                          req_valid,
	input  compute_unit_pkg::cu_id_t      req_cu_id,
	input  compute_unit_pkg::edge_index_t req_edge_index,
	input  cache_line_pkg::line_address_t edge_base_address,
	output logic                          cmd_valid,
	output cache_line_pkg::line_address_t cmd_address,
	output compute_unit_pkg::cu_id_t      cmd_cu_id,
	output cache_line_pkg::word_offset_t  cmd_offset
);
	import cache_line_pkg::*;
	import compute_unit_pkg::*;

	logic enabled;

	// Index split
	logic [EDGE_INDEX_BITS-OFFSET_BITS-1:0] line_index;
	word_offset_t                           word_offset;
	line_address_t                          line_address;

	// Command register
	logic          cmd_valid_q;
	line_address_t cmd_address_q;
	cu_id_t        cmd_cu_id_q;
	word_offset_t  cmd_offset_q;

	//////////////////////////////
	// Enable register
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enabled_in;
		end
	end

	//////////////////////////////
	// Address decode
	//////////////////////////////

	// Low bits name the word, upper bits the line
	assign word_offset = req_edge_index[OFFSET_BITS-1:0];
	assign line_index  = req_edge_index[EDGE_INDEX_BITS-1:OFFSET_BITS];

	// Base plus line index times line size
	assign line_address = edge_base_address
		+ (line_address_t'(line_index) * line_address_t'(CACHELINE_BYTES));

	//////////////////////////////
	// Command register
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_valid_q   <= 1'b0;
			cmd_address_q <= '0;
			cmd_cu_id_q   <= '0;
			cmd_offset_q  <= '0;
		end else if (enabled) begin
			cmd_valid_q <= req_valid;
			// Payload only moves with a request
			if (req_valid) begin
				cmd_address_q <= line_address;
				cmd_cu_id_q   <= req_cu_id;
				cmd_offset_q  <= word_offset;
			end
		end
	end

	// A frozen command shows once enable returns
	assign cmd_valid   = cmd_valid_q & enabled;
	assign cmd_address = cmd_address_q;
	assign cmd_cu_id   = cmd_cu_id_q;
	assign cmd_offset  = cmd_offset_q;

	// Request fields fully known whenever a request is offered
	a_req_known: assert property (@(posedge clock) disable iff (!rstn)
		req_valid |-> !$isunknown({req_cu_id, req_edge_index, edge_base_address}))
	else $error("edge request carries unknown bits");

endmodule

// ==== edge_data_read/edge_response_pairing.sv ====
// Execute stage, aligns the two tagged response halves and pairs them into one line
`timescale 1ns/100ps

module edge_response_pairing (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         enabled_in,
	input  logic                         rsp0_valid,
	input  compute_unit_pkg::cu_id_t     rsp0_cu_id,
	input  cache_line_pkg::word_offset_t rsp0_offset,
	input  cache_line_pkg::half_line_t   rsp0_data,
	input  logic                         rsp1_valid,
	input  compute_unit_pkg::cu_id_t     rsp1_cu_id,
	input  cache_line_pkg::word_offset_t rsp1_offset,
	input  cache_line_pkg::half_line_t   rsp1_data,
	line_pair_if.execute                 pair
);
	import cache_line_pkg::*;
	import compute_unit_pkg::*;

	logic enabled;

	// Half 0 first latch
	logic         rsp0_early_valid;
	cu_id_t       rsp0_early_cu_id;
	word_offset_t rsp0_early_offset;
	half_line_t   rsp0_early_data;

	// Half 0 second latch, lines up with half 1
	logic         rsp0_late_valid;
	cu_id_t       rsp0_late_cu_id;
	word_offset_t rsp0_late_offset;
	half_line_t   rsp0_late_data;

	// Half 1 single latch
	logic       rsp1_late_valid;
	half_line_t rsp1_late_data;

	// Paired line register
	logic         pair_valid_q;
	cu_id_t       pair_cu_id_q;
	word_offset_t pair_offset_q;
	half_line_t   pair_half_0_q;
	half_line_t   pair_half_1_q;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enabled_in;
		end
	end

	//////////////////////////////
	// Latch stage
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rsp0_early_valid  <= 1'b0;
			rsp0_early_cu_id  <= '0;
			rsp0_early_offset <= '0;
			rsp0_early_data   <= '0;
			rsp0_late_valid   <= 1'b0;
			rsp0_late_cu_id   <= '0;
			rsp0_late_offset  <= '0;
			rsp0_late_data    <= '0;
			rsp1_late_valid   <= 1'b0;
			rsp1_late_data    <= '0;
		end else if (enabled) begin
			// Extra delay on half 0 absorbs the one cycle skew
			rsp0_early_valid  <= rsp0_valid;
			rsp0_early_cu_id  <= rsp0_cu_id;
			rsp0_early_offset <= rsp0_offset;
			rsp0_early_data   <= rsp0_data;
			rsp0_late_valid   <= rsp0_early_valid;
			rsp0_late_cu_id   <= rsp0_early_cu_id;
			rsp0_late_offset  <= rsp0_early_offset;
			rsp0_late_data    <= rsp0_early_data;
			rsp1_late_valid   <= rsp1_valid;
			rsp1_late_data    <= rsp1_data;
		end
	end

	//////////////////////////////
	// Pair stage
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pair_valid_q  <= 1'b0;
			pair_cu_id_q  <= '0;
			pair_offset_q <= '0;
			pair_half_0_q <= '0;
			pair_half_1_q <= '0;
		end else if (enabled) begin
			pair_valid_q <= rsp0_late_valid & rsp1_late_valid;
			// Tag comes from half 0
			if (rsp0_late_valid && rsp1_late_valid) begin
				pair_cu_id_q  <= rsp0_late_cu_id;
				pair_offset_q <= rsp0_late_offset;
				pair_half_0_q <= rsp0_late_data;
				pair_half_1_q <= rsp1_late_data;
			end
		end
	end

	assign pair.valid  = pair_valid_q & enabled;
	assign pair.cu_id  = pair_cu_id_q;
	assign pair.offset = pair_offset_q;
	assign pair.half_0 = pair_half_0_q;
	assign pair.half_1 = pair_half_1_q;

	// Half 1 always one cycle behind half 0
	a_half_order: assert property (@(posedge clock) disable iff (!rstn)
		rsp0_valid |=> rsp1_valid)
	else $error("half 1 missing one cycle after half 0");

	a_half_lone: assert property (@(posedge clock) disable iff (!rstn)
		rsp1_valid |-> $past(rsp0_valid))
	else $error("half 1 arrived without half 0 before it");

	// Both halves carry the same command tag
	a_half_tag: assert property (@(posedge clock) disable iff (!rstn)
		rsp1_valid |-> (rsp1_cu_id == $past(rsp0_cu_id))
			&& (rsp1_offset == $past(rsp0_offset)))
	else $error("tags of the two halves differ");

endmodule

// ==== edge_data_read/edge_word_extract.sv ====
// Result stage, selects the tagged word of a paired line and returns it in host byte order
`timescale 1ns/100ps

module edge_word_extract (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled_in,
	line_pair_if.result                 pair,
	output logic                        edge_valid,
	output compute_unit_pkg::cu_id_t    edge_cu_id,
	output compute_unit_pkg::edge_word_t edge_data
);
	import cache_line_pkg::*;
	import compute_unit_pkg::*;

	logic enabled;

	// Word select decode
	logic                   upper_half;
	logic [OFFSET_BITS-2:0] word_index;
	edge_word_t             picked_word;

	// Select register, still memory order
	logic       sel_valid;
	cu_id_t     sel_cu_id;
	edge_word_t sel_word;

	// Output register, host order
	logic       edge_valid_q;
	cu_id_t     edge_cu_id_q;
	edge_word_t edge_data_q;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enabled_in;
		end
	end

	//////////////////////////////
	// Word select
	//////////////////////////////

	// Upper offsets live in half 1
	assign upper_half = (pair.offset >= word_offset_t'(WORDS_PER_HALF));
	assign word_index = pair.offset[OFFSET_BITS-2:0];

	assign picked_word = upper_half
		? pair.half_1[word_index*WORD_BITS +: WORD_BITS]
		: pair.half_0[word_index*WORD_BITS +: WORD_BITS];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			sel_valid <= 1'b0;
			sel_cu_id <= '0;
			sel_word  <= '0;
		end else if (enabled) begin
			sel_valid <= pair.valid;
			if (pair.valid) begin
				sel_cu_id <= pair.cu_id;
				sel_word  <= picked_word;
			end
		end
	end

	//////////////////////////////
	// Swap and output
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_valid_q <= 1'b0;
			edge_cu_id_q <= '0;
			edge_data_q  <= '0;
		end else if (enabled) begin
			edge_valid_q <= sel_valid;
			// Big endian memory word to host order
			if (sel_valid) begin
				edge_cu_id_q <= sel_cu_id;
				edge_data_q  <= swap_word_bytes(sel_word);
			end
		end
	end

	// Held result surfaces on the first enabled cycle
	assign edge_valid = edge_valid_q & enabled;
	assign edge_cu_id = edge_cu_id_q;
	assign edge_data  = edge_data_q;

	// Two enabled cycles from paired line to result
	a_result_latency: assert property (@(posedge clock) disable iff (!rstn)
		(edge_valid && $past(enabled) && $past(enabled, 2)) |-> $past(pair.valid, 2))
	else $error("edge result without a paired line two cycles before");

endmodule

// ==== edge_data_read/edge_data_read_top.sv ====
// Edge data read path top level, request decode to host order edge word on plain ports
`timescale 1ns/100ps

module edge_data_read_top (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          enabled_in,
	// Compute unit request
	input  logic                          req_valid,
	input  compute_unit_pkg::cu_id_t      req_cu_id,
	input  compute_unit_pkg::edge_index_t req_edge_index,
	input  cache_line_pkg::line_address_t edge_base_address,
	// Read command to memory
	output logic                          cmd_valid,
	output cache_line_pkg::line_address_t cmd_address,
	output compute_unit_pkg::cu_id_t      cmd_cu_id,
	output cache_line_pkg::word_offset_t  cmd_offset,
	// Memory response halves
	input  logic                          rsp0_valid,
	input  compute_unit_pkg::cu_id_t      rsp0_cu_id,
	input  cache_line_pkg::word_offset_t  rsp0_offset,
	input  cache_line_pkg::half_line_t    rsp0_data,
	input  logic                          rsp1_valid,
	input  compute_unit_pkg::cu_id_t      rsp1_cu_id,
	input  cache_line_pkg::word_offset_t  rsp1_offset,
	input  cache_line_pkg::half_line_t    rsp1_data,
	// Edge result to the compute unit
	output logic                          edge_valid,
	output compute_unit_pkg::cu_id_t      edge_cu_id,
	output compute_unit_pkg::edge_word_t  edge_data
);

	// Paired line between execute and result stages
	line_pair_if pair_bus ();

	//////////////////////////////
	// Stages
	//////////////////////////////

	edge_read_request_decode u_decode (
		.clock             (clock),
		.rstn              (rstn),
		.enabled_in        (enabled_in),
		.req_valid         (req_valid),
		.req_cu_id         (req_cu_id),
		.req_edge_index    (req_edge_index),
		.edge_base_address (edge_base_address),
		.cmd_valid         (cmd_valid),
		.cmd_address       (cmd_address),
		.cmd_cu_id         (cmd_cu_id),
		.cmd_offset        (cmd_offset)
	);

	edge_response_pairing u_pairing (
		.clock       (clock),
		.rstn        (rstn),
		.enabled_in  (enabled_in),
		.rsp0_valid  (rsp0_valid),
		.rsp0_cu_id  (rsp0_cu_id),
		.rsp0_offset (rsp0_offset),
		.rsp0_data   (rsp0_data),
		.rsp1_valid  (rsp1_valid),
		.rsp1_cu_id  (rsp1_cu_id),
		.rsp1_offset (rsp1_offset),
		.rsp1_data   (rsp1_data),
		.pair        (pair_bus)
	);

	edge_word_extract u_extract (
		.clock      (clock),
		.rstn       (rstn),
		.enabled_in (enabled_in),
		.pair       (pair_bus),
		.edge_valid (edge_valid),
		.edge_cu_id (edge_cu_id),
		.edge_data  (edge_data)
	);

endmodule

// ==== dv/edge_line_memory_model.sv ====
// Testbench memory model, answers each read command with two tagged half-line responses
`timescale 1ns/100ps

module edge_line_memory_model (
	input  logic                          clock,
	input  logic                          cmd_valid,
	input  cache_line_pkg::line_address_t cmd_address,
	input  compute_unit_pkg::cu_id_t      cmd_cu_id,
	input  cache_line_pkg::word_offset_t  cmd_offset,
	output logic                          rsp0_valid,
	output compute_unit_pkg::cu_id_t      rsp0_cu_id,
	output cache_line_pkg::word_offset_t  rsp0_offset,
	output cache_line_pkg::half_line_t    rsp0_data,
	output logic                          rsp1_valid,
	output compute_unit_pkg::cu_id_t      rsp1_cu_id,
	output cache_line_pkg::word_offset_t  rsp1_offset,
	output cache_line_pkg::half_line_t    rsp1_data
);
	import cache_line_pkg::*;
	import compute_unit_pkg::*;

	// Cycles from command to half 0, half 1 one cycle later
	localparam int RSP_DELAY = 3;

	// Pending command delay line
	logic          pend_valid   [0:RSP_DELAY];
	line_address_t pend_address [0:RSP_DELAY];
	cu_id_t        pend_cu_id   [0:RSP_DELAY];
	word_offset_t  pend_offset  [0:RSP_DELAY];

	// Word k of the line at A holds A + 4k
	function automatic half_line_t fill_half(input line_address_t address, input int half);
		half_line_t    data;
		line_address_t word_address;
		data = '0;
		for (int j = 0; j < WORDS_PER_HALF; j++) begin
			word_address = address + line_address_t'(4 * (half * WORDS_PER_HALF + j));
			data[j*WORD_BITS +: WORD_BITS] = word_address[WORD_BITS-1:0];
		end
		return data;
	endfunction

	initial begin
		for (int s = 0; s <= RSP_DELAY; s++) begin
			pend_valid[s]   = 1'b0;
			pend_address[s] = '0;
			pend_cu_id[s]   = '0;
			pend_offset[s]  = '0;
		end
		rsp0_valid  = 1'b0;
		rsp0_cu_id  = '0;
		rsp0_offset = '0;
		rsp0_data   = '0;
		rsp1_valid  = 1'b0;
		rsp1_cu_id  = '0;
		rsp1_offset = '0;
		rsp1_data   = '0;
	end

	//////////////////////////////
	// Response drive
	//////////////////////////////

	// Commands sampled and halves driven on the falling edge
	always @(negedge clock) begin
		for (int s = RSP_DELAY; s > 0; s--) begin
			pend_valid[s]   = pend_valid[s-1];
			pend_address[s] = pend_address[s-1];
			pend_cu_id[s]   = pend_cu_id[s-1];
			pend_offset[s]  = pend_offset[s-1];
		end
		pend_valid[0]   = (cmd_valid === 1'b1);
		pend_address[0] = cmd_address;
		pend_cu_id[0]   = cmd_cu_id;
		pend_offset[0]  = cmd_offset;
		// Half 0 first
		rsp0_valid  = pend_valid[RSP_DELAY-1];
		rsp0_cu_id  = pend_cu_id[RSP_DELAY-1];
		rsp0_offset = pend_offset[RSP_DELAY-1];
		rsp0_data   = pend_valid[RSP_DELAY-1] ? fill_half(pend_address[RSP_DELAY-1], 0) : '0;
		// Half 1 on the next cycle, same tag
		rsp1_valid  = pend_valid[RSP_DELAY];
		rsp1_cu_id  = pend_cu_id[RSP_DELAY];
		rsp1_offset = pend_offset[RSP_DELAY];
		rsp1_data   = pend_valid[RSP_DELAY] ? fill_half(pend_address[RSP_DELAY], 1) : '0;
	end

endmodule

// ==== dv/edge_data_read_tb.sv ====
// Self-checking testbench for the edge data read path that runs as the simulation top
`timescale 1ns/100ps

module edge_data_read_tb;
	import cache_line_pkg::*;
	import compute_unit_pkg::*;

	//////////////////////////////
	// Run constants
	//////////////////////////////

	localparam int TEST_COUNT      = 18;
	localparam int RESET_CYCLES    = 8;
	localparam int IDLE_CYCLES     = 6;
	localparam int HOLD_CYCLES     = 6;
	// Rising edge sampling half 1 to rising edge sampling the result
	localparam int RESULT_LATENCY  = 4;
	localparam int WATCHDOG_CYCLES = TEST_COUNT * 20 + 100;

	// One row of the stimulus table
	typedef struct packed {
		cu_id_t      cu_id;
		edge_index_t index;
		int          gap;
		logic        drop;
		edge_word_t  exp_data;
	} test_entry_t;

	logic          clock;
	logic          rstn;
	logic          enabled_in;
	logic          req_valid;
	cu_id_t        req_cu_id;
	edge_index_t   req_edge_index;
	line_address_t edge_base_address;
	logic          cmd_valid;
	line_address_t cmd_address;
	cu_id_t        cmd_cu_id;
	word_offset_t  cmd_offset;
	logic          rsp0_valid;
	cu_id_t        rsp0_cu_id;
	word_offset_t  rsp0_offset;
	half_line_t    rsp0_data;
	logic          rsp1_valid;
	cu_id_t        rsp1_cu_id;
	word_offset_t  rsp1_offset;
	half_line_t    rsp1_data;
	logic          edge_valid;
	cu_id_t        edge_cu_id;
	edge_word_t    edge_data;

	// Table plus result bookkeeping
	test_entry_t test_table [TEST_COUNT];
	int          rsp1_cycle [TEST_COUNT];
	bit          cmd_failed [TEST_COUNT];
	int          cycle        = 0;
	int          rsp1_seen    = 0;
	int          next_cmd     = 0;
	int          next_result  = 0;
	int          failed_tests = 0;
	int          check_errors = 0;
	int          hold_errors  = 0;
	int          reset_errors = 0;

	edge_data_read_top u_dut (
		.clock             (clock),
		.rstn              (rstn),
		.enabled_in        (enabled_in),
		.req_valid         (req_valid),
		.req_cu_id         (req_cu_id),
		.req_edge_index    (req_edge_index),
		.edge_base_address (edge_base_address),
		.cmd_valid         (cmd_valid),
		.cmd_address       (cmd_address),
		.cmd_cu_id         (cmd_cu_id),
		.cmd_offset        (cmd_offset),
		.rsp0_valid        (rsp0_valid),
		.rsp0_cu_id        (rsp0_cu_id),
		.rsp0_offset       (rsp0_offset),
		.rsp0_data         (rsp0_data),
		.rsp1_valid        (rsp1_valid),
		.rsp1_cu_id        (rsp1_cu_id),
		.rsp1_offset       (rsp1_offset),
		.rsp1_data         (rsp1_data),
		.edge_valid        (edge_valid),
		.edge_cu_id        (edge_cu_id),
		.edge_data         (edge_data)
	);

	edge_line_memory_model u_memory (
		.clock       (clock),
		.cmd_valid   (cmd_valid),
		.cmd_address (cmd_address),
		.cmd_cu_id   (cmd_cu_id),
		.cmd_offset  (cmd_offset),
		.rsp0_valid  (rsp0_valid),
		.rsp0_cu_id  (rsp0_cu_id),
		.rsp0_offset (rsp0_offset),
		.rsp0_data   (rsp0_data),
		.rsp1_valid  (rsp1_valid),
		.rsp1_cu_id  (rsp1_cu_id),
		.rsp1_offset (rsp1_offset),
		.rsp1_data   (rsp1_data)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	//////////////////////////////
	// Table and expected values
	//////////////////////////////

	// Memory word at base + 4 * index with its bytes reversed into host order
	function automatic edge_word_t expected_word(input line_address_t base, input edge_index_t index);
		line_address_t byte_address;
		edge_word_t    mem_word;
		edge_word_t    host_word;
		byte_address = base + (line_address_t'(index) << 2);
		mem_word = byte_address[31:0];
		for (int b = 0; b < 4; b++) begin
			host_word[8*b +: 8] = mem_word[8*(3-b) +: 8];
		end
		return host_word;
	endfunction

	// Line of 32 words holding the edge, 128 bytes per line above the base
	function automatic line_address_t command_address(input line_address_t base,
		input edge_index_t index);
		return base + line_address_t'(index / 32) * 64'd128;
	endfunction

	task automatic set_entry(input int slot, input edge_index_t index, input int gap,
		input logic drop);
		test_table[slot].cu_id    = cu_id_t'($urandom());
		test_table[slot].index    = index;
		test_table[slot].gap      = gap;
		test_table[slot].drop     = drop;
		test_table[slot].exp_data = expected_word(edge_base_address, index);
	endtask

	task automatic build_table();
		// Offsets in half 0
		set_entry(0, 32'd0, 10, 1'b0);
		set_entry(1, 32'd7, 10, 1'b0);
		set_entry(2, 32'd15, 10, 1'b0);
		// Offsets in half 1
		set_entry(3, 32'd16, 10, 1'b0);
		set_entry(4, 32'd31, 10, 1'b0);
		// Further lines for address arithmetic
		set_entry(5, 32'd52, 10, 1'b0);
		set_entry(6, 32'h0000_1234, 10, 1'b0);
		set_entry(7, 32'hffff_ffe3, 12, 1'b0);
		// Eight back to back
		set_entry(8, 32'd64, 0, 1'b0);
		set_entry(9, 32'd97, 0, 1'b0);
		set_entry(10, 32'd130, 0, 1'b0);
		set_entry(11, 32'd159, 0, 1'b0);
		set_entry(12, 32'd200, 0, 1'b0);
		set_entry(13, 32'd255, 0, 1'b0);
		set_entry(14, 32'd33, 0, 1'b0);
		set_entry(15, 32'd1, 12, 1'b0);
		// Enable dropped while the line is in flight
		set_entry(16, 32'd45, 10, 1'b1);
		set_entry(17, 32'd2, 10, 1'b0);
	endtask

	//////////////////////////////
	// Stimulus tasks
	//////////////////////////////

	task automatic check_idle_after_reset();
		int errors;
		errors = 0;
		repeat (IDLE_CYCLES) begin
			@(negedge clock);
			if (cmd_valid !== 1'b0) begin
				$display("Mismatch cmd_valid: got %h, expected %h", cmd_valid, 1'b0);
				errors++;
			end
			if (edge_valid !== 1'b0) begin
				$display("Mismatch edge_valid: got %h, expected %h", edge_valid, 1'b0);
				errors++;
			end
			if (edge_data !== 32'h0) begin
				$display("Mismatch edge_data: got %h, expected %h", edge_data, 32'h0);
				errors++;
			end
		end
		reset_errors = errors;
		if (errors == 0)
			$display("test 0 idle after reset: passed");
		else
			$display("test 0 idle after reset: failed");
	endtask

	// Freeze once half 1 of this row is sampled and release later
	task automatic hold_enable(input int slot);
		while (rsp1_seen < slot + 1)
			@(negedge clock);
		enabled_in = 1'b0;
		repeat (HOLD_CYCLES) begin
			@(negedge clock);
			if (edge_valid !== 1'b0) begin
				$display("edge_valid rose while enable was low during test %0d", slot + 1);
				hold_errors++;
			end
		end
		enabled_in = 1'b1;
	endtask

	task automatic apply_table();
		for (int i = 0; i < TEST_COUNT; i++) begin
			@(negedge clock);
			req_valid      = 1'b1;
			req_cu_id      = test_table[i].cu_id;
			req_edge_index = test_table[i].index;
			// Zero gap rows keep req_valid high
			if (test_table[i].gap > 0 || test_table[i].drop || i == TEST_COUNT - 1) begin
				@(negedge clock);
				req_valid = 1'b0;
				if (test_table[i].drop)
					hold_enable(i);
				if (test_table[i].gap > 1)
					repeat (test_table[i].gap - 1) @(negedge clock);
			end
		end
	endtask

	//////////////////////////////
	// Monitors
	//////////////////////////////

	// Cycle count and rising edges that sample half 1
	always @(posedge clock) begin
		cycle = cycle + 1;
		if (rsp1_valid === 1'b1 && rsp1_seen < TEST_COUNT) begin
			rsp1_cycle[rsp1_seen] = cycle;
			rsp1_seen = rsp1_seen + 1;
		end
	end

	// Read commands leave in request order
	always @(negedge clock) begin : check_commands
		line_address_t exp_address;
		word_offset_t  exp_offset;
		if (cmd_valid === 1'b1) begin
			if (next_cmd >= TEST_COUNT) begin
				$display("cmd_valid seen after all %0d commands had been issued", TEST_COUNT);
				check_errors++;
			end else begin
				exp_address = command_address(edge_base_address, test_table[next_cmd].index);
				exp_offset  = word_offset_t'(test_table[next_cmd].index % 32);
				if (cmd_address !== exp_address) begin
					$display("Mismatch cmd_address: got %h, expected %h",
						cmd_address, exp_address);
					cmd_failed[next_cmd] = 1'b1;
				end
				if (cmd_cu_id !== test_table[next_cmd].cu_id) begin
					$display("Mismatch cmd_cu_id: got %h, expected %h",
						cmd_cu_id, test_table[next_cmd].cu_id);
					cmd_failed[next_cmd] = 1'b1;
				end
				if (cmd_offset !== exp_offset) begin
					$display("Mismatch cmd_offset: got %h, expected %h",
						cmd_offset, exp_offset);
					cmd_failed[next_cmd] = 1'b1;
				end
				next_cmd++;
			end
		end
	end

	// Results come back in request order
	always @(negedge clock) begin : check_results
		int   latency;
		logic row_failed;
		if (edge_valid === 1'b1) begin
			if (next_result >= TEST_COUNT) begin
				$display("edge_valid seen after all %0d results had arrived", TEST_COUNT);
				check_errors++;
			end else begin
				// A bad command already marks the row
				row_failed = cmd_failed[next_result];
				if (edge_data !== test_table[next_result].exp_data) begin
					$display("Mismatch edge_data: got %h, expected %h",
						edge_data, test_table[next_result].exp_data);
					row_failed = 1'b1;
				end
				if (edge_cu_id !== test_table[next_result].cu_id) begin
					$display("Mismatch edge_cu_id: got %h, expected %h",
						edge_cu_id, test_table[next_result].cu_id);
					row_failed = 1'b1;
				end
				if (test_table[next_result].drop) begin
					if (hold_errors != 0)
						row_failed = 1'b1;
				end else if (rsp1_seen <= next_result) begin
					$display("result of test %0d arrived before its half 1", next_result + 1);
					row_failed = 1'b1;
				end else begin
					// Consumer samples on the next rising edge
					latency = cycle + 1 - rsp1_cycle[next_result];
					if (latency != RESULT_LATENCY) begin
						$display("test %0d result took %0d cycles after half 1, expected %0d",
							next_result + 1, latency, RESULT_LATENCY);
						row_failed = 1'b1;
					end
				end
				if (row_failed) begin
					failed_tests++;
					$display("test %0d index %h: failed", next_result + 1,
						test_table[next_result].index);
				end else begin
					$display("test %0d index %h: passed", next_result + 1,
						test_table[next_result].index);
				end
				next_result++;
			end
		end
	end

	// Stops a run whose results never arrive
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("Watchdog expired: results never arrived, %0d of %0d tests finished",
			next_result, TEST_COUNT);
		$display("Test FAILED");
		$finish;
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		int total_failed;
		void'($urandom(32'h1ed6));
		rstn              = 1'b0;
		enabled_in        = 1'b1;
		req_valid         = 1'b0;
		req_cu_id         = '0;
		req_edge_index    = '0;
		edge_base_address = {$urandom(), $urandom()} & ~64'h3;
		build_table();
		$display("edge_base_address %h", edge_base_address);
		repeat (RESET_CYCLES) @(negedge clock);
		rstn = 1'b1;
		check_idle_after_reset();
		apply_table();
		while (next_result < TEST_COUNT)
			@(posedge clock);
		// Extra cycles catch stray results
		repeat (IDLE_CYCLES) @(negedge clock);
		total_failed = failed_tests + ((reset_errors != 0) ? 1 : 0);
		$display("Summary: %0d tests, %0d passed, %0d failed, %0d other errors",
			TEST_COUNT + 1, TEST_COUNT + 1 - total_failed, total_failed,
			check_errors + hold_errors);
		if (total_failed == 0 && check_errors == 0 && hold_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
common/cache_line_pkg.sv
common/compute_unit_pkg.sv
common/line_pair_if.sv
hdl/edge_read_request_decode.sv
edge_data_read/edge_response_pairing.sv
edge_data_read/edge_word_extract.sv
edge_data_read/edge_data_read_top.sv
dv/edge_line_memory_model.sv
dv/edge_data_read_tb.sv

// ==== Makefile ====
TOOL      := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       := edge_data_read_tb
FILE_LIST := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Test FAILED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
